// File: hdl/ooo_pkg.sv
package ooo_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_len = 4;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_addi = 3'd5,
        alu_slt  = 3'd6
    } alu_op_e;

    typedef enum logic [2:0] {
        br_beq = 3'd0,
        br_bne = 3'd1,
        br_blt = 3'd2
    } br_cond_e;

    // bit 31 clear, imm only read by addi
    typedef struct packed {
        logic                    is_branch;
        alu_op_e                 op;
        logic [reg_addr_len-1:0] rd;
        logic [reg_addr_len-1:0] rs1;
        logic [reg_addr_len-1:0] rs2;
        logic [15:0]             imm;
    } alu_fmt_t;

    // bit 31 set, offset in bytes from the branch pc
    typedef struct packed {
        logic                    is_branch;
        br_cond_e                cond;
        logic [3:0]              unused;
        logic [reg_addr_len-1:0] rs1;
        logic [reg_addr_len-1:0] rs2;
        logic [15:0]             offset;
    } br_fmt_t;

    typedef union packed {
        alu_fmt_t alu;
        br_fmt_t  br;
    } instr_word_u;

    typedef struct packed {
        logic                    valid;
        logic                    ready;
        logic                    mispredict;
        logic [reg_addr_len-1:0] wb_reg;
        logic [xlen-1:0]         wb_data;
        logic [xlen-1:0]         npc;
    } rob_entry_t;

endpackage

// File: hdl/ooo_ifs.sv
`timescale 1ns/100ps

interface issue_if #(
    parameter int ROB_DEPTH = 8
) ();
    localparam int tag_len = $clog2(ROB_DEPTH);

    logic                     valid;
    logic [tag_len-1:0]       tag;
    ooo_pkg::instr_word_u     instr;
    logic [ooo_pkg::xlen-1:0] pc;
    logic [ooo_pkg::xlen-1:0] src1;
    logic [ooo_pkg::xlen-1:0] src2;
    logic                     ready;

    modport source (output valid, tag, instr, pc, src1, src2, input ready);
    modport sink (input valid, tag, instr, pc, src1, src2, output ready);
endinterface

interface cdb_if #(
    parameter int ROB_DEPTH = 8
) ();
    localparam int tag_len = $clog2(ROB_DEPTH);

    logic                     valid;
    logic [tag_len-1:0]       tag;
    logic [ooo_pkg::xlen-1:0] data;
    logic [ooo_pkg::xlen-1:0] target;
    logic                     mispredict;
    logic                     grant;

    // unit side and arbiter side of one result stream
    modport result (output valid, tag, data, target, mispredict, input grant);
    modport arb (input valid, tag, data, target, mispredict, output grant);
    // shared bus, grant here means the rob takes the write
    modport bus (output valid, tag, data, target, mispredict, input grant);
    modport sink (input valid, tag, data, target, mispredict, output grant);
endinterface

// File: hdl/arch_regfile.sv
`timescale 1ns/100ps

module arch_regfile #(
    parameter int ROB_DEPTH = 8,
    localparam int tag_len = $clog2(ROB_DEPTH)
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [ooo_pkg::reg_addr_len-1:0] rd_addr1,
    input  logic [ooo_pkg::reg_addr_len-1:0] rd_addr2,
    output logic [ooo_pkg::xlen-1:0]         rd_data1,
    output logic [ooo_pkg::xlen-1:0]         rd_data2,
    output logic                             rd_pending1,
    output logic                             rd_pending2,
    output logic [tag_len-1:0]               rd_tag1,
    output logic [tag_len-1:0]               rd_tag2,
    input  logic                             claim,
    input  logic [ooo_pkg::reg_addr_len-1:0] claim_reg,
    input  logic [tag_len-1:0]               claim_tag,
    input  logic                             commit_valid,
    input  logic [ooo_pkg::reg_addr_len-1:0] commit_reg,
    input  logic [ooo_pkg::xlen-1:0]         commit_data,
    input  logic [tag_len-1:0]               commit_tag,
    input  logic                             flush
);
    localparam int num_regs = 2 ** ooo_pkg::reg_addr_len;

    logic [ooo_pkg::xlen-1:0] regs [num_regs];
    logic [num_regs-1:0]      pending;
    logic [tag_len-1:0]       tags [num_regs];

    // register 0 is hardwired, a retiring write shows through
    function automatic logic [ooo_pkg::xlen-1:0] read_data(
        input logic [ooo_pkg::reg_addr_len-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (commit_valid && commit_reg == addr) begin
            return commit_data;
        end
        return regs[addr];
    endfunction

    // producer retiring this cycle no longer counts as pending
    function automatic logic read_pending(
        input logic [ooo_pkg::reg_addr_len-1:0] addr
    );
        logic retiring;
        retiring = commit_valid && commit_reg == addr && commit_tag == tags[addr];
        return pending[addr] && !retiring;
    endfunction

    always_comb begin
        rd_data1    = read_data(rd_addr1);
        rd_data2    = read_data(rd_addr2);
        rd_pending1 = read_pending(rd_addr1);
        rd_pending2 = read_pending(rd_addr2);
        rd_tag1     = tags[rd_addr1];
        rd_tag2     = tags[rd_addr2];
    end

    always_ff @(posedge clk) begin
        if (commit_valid && commit_reg != '0) begin
            regs[commit_reg] <= commit_data;
        end
        if (claim) begin
            tags[claim_reg] <= claim_tag;
        end
    end

    // a claim in the same cycle overrides the clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else if (flush) begin
            pending <= '0;
        end else begin
            if (commit_valid && commit_tag == tags[commit_reg]) begin
                pending[commit_reg] <= 1'b0;
            end
            if (claim) begin
                pending[claim_reg] <= 1'b1;
            end
        end
    end

    // dispatch never renames the zero register
    assert property (@(posedge clk) disable iff (!arst_n) claim |-> claim_reg != '0);

endmodule

// File: hdl/dispatch_unit.sv
`timescale 1ns/100ps

module dispatch_unit #(
    parameter int ROB_DEPTH = 8,
    localparam int tag_len = $clog2(ROB_DEPTH)
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             instr_valid,
    input  logic [ooo_pkg::xlen-1:0]         instr,
    input  logic [ooo_pkg::xlen-1:0]         pc,
    output logic                             instr_ready,
    output logic [ooo_pkg::reg_addr_len-1:0] rd_addr1,
    output logic [ooo_pkg::reg_addr_len-1:0] rd_addr2,
    input  logic [ooo_pkg::xlen-1:0]         rd_data1,
    input  logic [ooo_pkg::xlen-1:0]         rd_data2,
    input  logic                             rd_pending1,
    input  logic                             rd_pending2,
    input  logic [tag_len-1:0]               rd_tag1,
    input  logic [tag_len-1:0]               rd_tag2,
    output logic                             claim,
    output logic [ooo_pkg::reg_addr_len-1:0] claim_reg,
    output logic [tag_len-1:0]               claim_tag,
    output logic                             dispatch,
    output logic [ooo_pkg::reg_addr_len-1:0] dispatch_reg,
    output logic [ooo_pkg::xlen-1:0]         dispatch_npc,
    input  logic [tag_len-1:0]               alloc_tag,
    input  logic                             rob_full,
    output logic [tag_len-1:0]               search_tag1,
    output logic [tag_len-1:0]               search_tag2,
    input  logic [ooo_pkg::xlen-1:0]         search_data1,
    input  logic [ooo_pkg::xlen-1:0]         search_data2,
    input  logic                             search_ready1,
    input  logic                             search_ready2,
    input  logic                             flush,
    issue_if.source                          alu_issue,
    issue_if.source                          br_issue
);
    ooo_pkg::instr_word_u             word;
    logic                             is_branch;
    logic [ooo_pkg::reg_addr_len-1:0] rd;
    logic                             needs_src2;
    logic                             src1_ok;
    logic                             src2_ok;
    logic                             unit_busy;
    logic                             accept;
    logic [ooo_pkg::xlen-1:0]         src1;
    logic [ooo_pkg::xlen-1:0]         src2;

    assign word      = instr;
    assign is_branch = word.alu.is_branch;
    assign rd        = word.alu.rd;
    assign rd_addr1  = is_branch ? word.br.rs1 : word.alu.rs1;
    assign rd_addr2  = is_branch ? word.br.rs2 : word.alu.rs2;
    // addi has no second source
    assign needs_src2 = is_branch || word.alu.op != ooo_pkg::alu_addi;

    // pending operands come from the rob once their entry is ready
    assign search_tag1 = rd_tag1;
    assign search_tag2 = rd_tag2;
    assign src1_ok     = !rd_pending1 || search_ready1;
    assign src2_ok     = !needs_src2 || !rd_pending2 || search_ready2;
    assign src1        = rd_pending1 ? search_data1 : rd_data1;
    assign src2        = rd_pending2 ? search_data2 : rd_data2;

    assign unit_busy = is_branch ? !br_issue.ready : alu_issue.valid && !alu_issue.ready;
    assign instr_ready = !rob_full && src1_ok && src2_ok && !unit_busy && !flush;
    assign accept      = instr_valid && instr_ready;

    assign dispatch     = accept;
    assign dispatch_reg = is_branch ? '0 : rd;
    assign dispatch_npc = pc + ooo_pkg::xlen'(4);
    assign claim        = accept && !is_branch && rd != '0;
    assign claim_reg    = rd;
    assign claim_tag    = alloc_tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_issue.valid <= 1'b0;
            br_issue.valid  <= 1'b0;
        end else if (flush) begin
            alu_issue.valid <= 1'b0;
            br_issue.valid  <= 1'b0;
        end else begin
            alu_issue.valid <= (accept && !is_branch) || (alu_issue.valid && !alu_issue.ready);
            br_issue.valid  <= (accept && is_branch) || (br_issue.valid && !br_issue.ready);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_branch) begin
            alu_issue.tag   <= alloc_tag;
            alu_issue.instr <= word;
            alu_issue.pc    <= pc;
            alu_issue.src1  <= src1;
            alu_issue.src2  <= src2;
        end
        if (accept && is_branch) begin
            br_issue.tag   <= alloc_tag;
            br_issue.instr <= word;
            br_issue.pc    <= pc;
            br_issue.src1  <= src1;
            br_issue.src2  <= src2;
        end
    end

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input logic   clk,
    input logic   arst_n,
    issue_if.sink issue,
    cdb_if.result result,
    input logic   flush
);
    logic                        s1_valid;
    logic [$bits(issue.tag)-1:0] s1_tag;
    logic [ooo_pkg::xlen-1:0]    s1_data;
    logic [ooo_pkg::xlen-1:0]    imm;
    logic [ooo_pkg::xlen-1:0]    alu_out;

    assign issue.ready       = 1'b1;
    assign result.target     = '0;
    assign result.mispredict = 1'b0;

    assign imm = {{16{issue.instr.alu.imm[15]}}, issue.instr.alu.imm};

    always_comb begin
        case (issue.instr.alu.op)
            ooo_pkg::alu_add:  alu_out = issue.src1 + issue.src2;
            ooo_pkg::alu_sub:  alu_out = issue.src1 - issue.src2;
            ooo_pkg::alu_and:  alu_out = issue.src1 & issue.src2;
            ooo_pkg::alu_or:   alu_out = issue.src1 | issue.src2;
            ooo_pkg::alu_xor:  alu_out = issue.src1 ^ issue.src2;
            ooo_pkg::alu_addi: alu_out = issue.src1 + imm;
            ooo_pkg::alu_slt:  alu_out = {31'd0, $signed(issue.src1) < $signed(issue.src2)};
            default:           alu_out = '0;
        endcase
    end

    // stage 1 holds the computed value, stage 2 is the cdb request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            result.valid <= 1'b0;
        end else if (flush) begin
            s1_valid     <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            s1_valid     <= issue.valid && issue.ready;
            result.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag      <= issue.tag;
        s1_data     <= alu_out;
        result.tag  <= s1_tag;
        result.data <= s1_data;
    end

    // no stall path here, the arbiter must always take alu results
    assert property (@(posedge clk) disable iff (!arst_n) result.valid |-> result.grant);

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
    input logic   clk,
    input logic   arst_n,
    issue_if.sink issue,
    cdb_if.result result,
    input logic   flush
);
    logic                     taken;
    logic [ooo_pkg::xlen-1:0] offset;

    assign offset = {{16{issue.instr.br.offset[15]}}, issue.instr.br.offset};

    always_comb begin
        case (issue.instr.br.cond)
            ooo_pkg::br_beq: taken = issue.src1 == issue.src2;
            ooo_pkg::br_bne: taken = issue.src1 != issue.src2;
            ooo_pkg::br_blt: taken = $signed(issue.src1) < $signed(issue.src2);
            default:         taken = 1'b0;
        endcase
    end

    // a waiting result blocks the next branch
    assign issue.ready = !result.valid || result.grant;
    assign result.data = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result.valid <= 1'b0;
        end else if (flush) begin
            result.valid <= 1'b0;
        end else if (issue.valid && issue.ready) begin
            result.valid <= 1'b1;
        end else if (result.grant) begin
            result.valid <= 1'b0;
        end
    end

    // predicted not taken, so taken is a mispredict
    always_ff @(posedge clk) begin
        if (issue.valid && issue.ready) begin
            result.tag        <= issue.tag;
            result.target     <= issue.pc + offset;
            result.mispredict <= taken;
        end
    end

endmodule

// File: hdl/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
    cdb_if.arb alu_res,
    cdb_if.arb br_res,
    cdb_if.bus bus
);
    // fixed priority, alu first
    always_comb begin
        alu_res.grant = alu_res.valid && bus.grant;
        br_res.grant  = br_res.valid && !alu_res.valid && bus.grant;
        bus.valid     = alu_res.grant || br_res.grant;
        if (alu_res.valid) begin
            bus.tag        = alu_res.tag;
            bus.data       = alu_res.data;
            bus.target     = alu_res.target;
            bus.mispredict = alu_res.mispredict;
        end else begin
            bus.tag        = br_res.tag;
            bus.data       = br_res.data;
            bus.target     = br_res.target;
            bus.mispredict = br_res.mispredict;
        end
        assert (!(alu_res.grant && br_res.grant))
        else $error("both result streams granted");
    end

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8,
    localparam int tag_len = $clog2(ROB_DEPTH)
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             dispatch,
    input  logic [ooo_pkg::reg_addr_len-1:0] dispatch_reg,
    input  logic [ooo_pkg::xlen-1:0]         dispatch_npc,
    output logic [tag_len-1:0]               alloc_tag,
    output logic                             rob_full,
    input  logic [tag_len-1:0]               search_tag1,
    input  logic [tag_len-1:0]               search_tag2,
    output logic [ooo_pkg::xlen-1:0]         search_data1,
    output logic [ooo_pkg::xlen-1:0]         search_data2,
    output logic                             search_ready1,
    output logic                             search_ready2,
    cdb_if.sink                              cdb,
    output logic                             commit_valid,
    output logic [ooo_pkg::reg_addr_len-1:0] commit_reg,
    output logic [ooo_pkg::xlen-1:0]         commit_data,
    output logic [ooo_pkg::xlen-1:0]         commit_npc,
    output logic [tag_len-1:0]               commit_tag,
    output logic                             flush
);
    ooo_pkg::rob_entry_t rob [ROB_DEPTH];
    ooo_pkg::rob_entry_t head_entry;
    logic [tag_len-1:0]  head;
    logic [tag_len-1:0]  tail;

    // retire straight from the head entry
    assign head_entry   = rob[head];
    assign commit_valid = head_entry.valid && head_entry.ready;
    assign commit_reg   = head_entry.wb_reg;
    assign commit_data  = head_entry.wb_data;
    assign commit_npc   = head_entry.npc;
    assign commit_tag   = head;
    assign flush        = commit_valid && head_entry.mispredict;

    // one slot stays free so head == tail means empty
    assign alloc_tag = tail;
    assign rob_full  = tag_len'(tail + 1'b1) == head;

    assign search_data1  = rob[search_tag1].wb_data;
    assign search_data2  = rob[search_tag2].wb_data;
    assign search_ready1 = rob[search_tag1].ready;
    assign search_ready2 = rob[search_tag2].ready;

    // every bus write is taken
    assign cdb.grant = 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob[i].valid <= 1'b0;
            end
        end else if (flush) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob[i].valid <= 1'b0;
            end
        end else begin
            if (dispatch) begin
                rob[tail] <= '{valid: 1'b1, ready: 1'b0, mispredict: 1'b0,
                               wb_reg: dispatch_reg, wb_data: '0, npc: dispatch_npc};
                tail <= tail + 1'b1;
            end
            if (cdb.valid) begin
                rob[cdb.tag].ready      <= 1'b1;
                rob[cdb.tag].wb_data    <= cdb.data;
                rob[cdb.tag].mispredict <= cdb.mispredict;
                // redirect the fall-through pc
                if (cdb.mispredict) begin
                    rob[cdb.tag].npc <= cdb.target;
                end
            end
            if (commit_valid) begin
                rob[head].valid <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) dispatch |-> !rob_full);
    assert property (@(posedge clk) disable iff (!arst_n) cdb.valid |-> rob[cdb.tag].valid);

endmodule

// File: hdl/ooo_core.sv
`timescale 1ns/100ps

module ooo_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             instr_valid,
    input  logic [ooo_pkg::xlen-1:0]         instr,
    input  logic [ooo_pkg::xlen-1:0]         pc,
    output logic                             instr_ready,
    output logic                             commit_valid,
    output logic [ooo_pkg::reg_addr_len-1:0] commit_reg,
    output logic [ooo_pkg::xlen-1:0]         commit_data,
    output logic [ooo_pkg::xlen-1:0]         commit_npc,
    output logic                             flush
);
    localparam int tag_len = $clog2(ROB_DEPTH);

    // register file reads and renaming
    logic [ooo_pkg::reg_addr_len-1:0] rd_addr1;
    logic [ooo_pkg::reg_addr_len-1:0] rd_addr2;
    logic [ooo_pkg::xlen-1:0]         rd_data1;
    logic [ooo_pkg::xlen-1:0]         rd_data2;
    logic                             rd_pending1;
    logic                             rd_pending2;
    logic [tag_len-1:0]               rd_tag1;
    logic [tag_len-1:0]               rd_tag2;
    logic                             claim;
    logic [ooo_pkg::reg_addr_len-1:0] claim_reg;
    logic [tag_len-1:0]               claim_tag;

    // rob allocation, operand search and retirement
    logic                             dispatch;
    logic [ooo_pkg::reg_addr_len-1:0] dispatch_reg;
    logic [ooo_pkg::xlen-1:0]         dispatch_npc;
    logic [tag_len-1:0]               alloc_tag;
    logic                             rob_full;
    logic [tag_len-1:0]               search_tag1;
    logic [tag_len-1:0]               search_tag2;
    logic [ooo_pkg::xlen-1:0]         search_data1;
    logic [ooo_pkg::xlen-1:0]         search_data2;
    logic                             search_ready1;
    logic                             search_ready2;
    logic [tag_len-1:0]               commit_tag;

    issue_if #(.ROB_DEPTH(ROB_DEPTH)) alu_issue ();
    issue_if #(.ROB_DEPTH(ROB_DEPTH)) br_issue ();
    cdb_if #(.ROB_DEPTH(ROB_DEPTH)) alu_res ();
    cdb_if #(.ROB_DEPTH(ROB_DEPTH)) br_res ();
    cdb_if #(.ROB_DEPTH(ROB_DEPTH)) cdb ();

    dispatch_unit #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (.*);

    arch_regfile #(.ROB_DEPTH(ROB_DEPTH)) u_regfile (.*);

    alu_unit u_alu (
        .clk,
        .arst_n,
        .issue  (alu_issue),
        .result (alu_res),
        .flush
    );

    branch_unit u_branch (
        .clk,
        .arst_n,
        .issue  (br_issue),
        .result (br_res),
        .flush
    );

    cdb_arbiter u_arbiter (
        .alu_res,
        .br_res,
        .bus (cdb)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (.*);

endmodule

// File: verification/ooo_ref_model.svh
`ifndef ooo_ref_model_svh
`define ooo_ref_model_svh

// expected commit of one instruction, regs holds the architectural state
function automatic void ref_execute(
    inout  logic [31:0] regs [16],
    input  logic [31:0] pc,
    input  logic [31:0] word,
    output logic [3:0]  exp_reg,
    output logic [31:0] exp_data,
    output logic [31:0] exp_npc,
    output logic        exp_flush
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic        taken;
    a         = regs[word[23:20]];
    b         = regs[word[19:16]];
    imm       = {{16{word[15]}}, word[15:0]};
    exp_npc   = pc + 32'd4;
    exp_flush = 1'b0;
    exp_reg   = 4'd0;
    exp_data  = 32'd0;
    if (word[31]) begin
        case (word[30:28])
            ooo_pkg::br_beq: taken = a == b;
            ooo_pkg::br_bne: taken = a != b;
            ooo_pkg::br_blt: taken = $signed(a) < $signed(b);
            default:         taken = 1'b0;
        endcase
        // not-taken prediction, so a taken branch redirects
        if (taken) begin
            exp_npc   = pc + imm;
            exp_flush = 1'b1;
        end
    end else begin
        case (word[30:28])
            ooo_pkg::alu_add:  exp_data = a + b;
            ooo_pkg::alu_sub:  exp_data = a - b;
            ooo_pkg::alu_and:  exp_data = a & b;
            ooo_pkg::alu_or:   exp_data = a | b;
            ooo_pkg::alu_xor:  exp_data = a ^ b;
            ooo_pkg::alu_addi: exp_data = a + imm;
            ooo_pkg::alu_slt:  exp_data = {31'd0, $signed(a) < $signed(b)};
            default:           exp_data = 32'd0;
        endcase
        exp_reg = word[27:24];
        // r0 stays zero
        if (exp_reg != 4'd0) begin
            regs[exp_reg] = exp_data;
        end
    end
endfunction

`endif

// File: verification/ooo_core_tb.sv
`timescale 1ns/100ps

module ooo_core_tb;

    localparam int rob_depth = 4;
    localparam int random_len = 200;
    localparam int drain_cycles = 20;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        instr_ready;
    logic        commit_valid;
    logic [3:0]  commit_reg;
    logic [31:0] commit_data;
    logic [31:0] commit_npc;
    logic        flush;

    logic [31:0] prog [512];
    int          prog_len;
    int          branch_count;
    logic [31:0] ref_regs [16];
    logic [31:0] ref_pc;
    logic        ref_done;
    logic        stim_go;
    int          error_count;
    int          commit_count;
    int          flush_count;

    `include "ooo_ref_model.svh"

    ooo_core #(.ROB_DEPTH(rob_depth)) dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] alu_word(input logic [2:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs1, input logic [3:0] rs2,
                                             input logic [15:0] imm);
        return {1'b0, op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] cond, input logic [3:0] rs1,
                                                input logic [3:0] rs2, input logic [15:0] offset);
        return {1'b1, cond, 4'd0, rs1, rs2, offset};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[9'(prog_len)] = word;
        prog_len++;
        if (word[31]) begin
            branch_count++;
        end
    endtask

    task automatic build_program();
        int k;
        // give every register a defined value first
        for (int r = 1; r < 16; r++) begin
            emit(alu_word(ooo_pkg::alu_addi, 4'(r), 4'd0, 4'd0, 16'($urandom)));
        end
        // one of each alu op with results kept apart from sources
        for (int op = 0; op < 7; op++) begin
            emit(alu_word(3'(op), 4'(8 + op), 4'(1 + op), 4'(7 - op), 16'hfff0 + 16'(op)));
        end
        emit(alu_word(ooo_pkg::alu_add, 4'd0, 4'd1, 4'd2, 16'd0));
        emit(alu_word(ooo_pkg::alu_or, 4'd5, 4'd0, 4'd0, 16'd0));
        // back-to-back raw chains
        for (int i = 0; i < 6; i++) begin
            emit(alu_word(ooo_pkg::alu_addi, 4'd1, 4'd1, 4'd0, 16'(i + 1)));
            emit(alu_word(ooo_pkg::alu_sub, 4'd2, 4'd1, 4'd2, 16'd0));
            emit(alu_word(ooo_pkg::alu_slt, 4'd3, 4'd2, 4'd1, 16'd0));
        end
        // taken branch with two wrong-path writes behind it
        emit(branch_word(ooo_pkg::br_beq, 4'd4, 4'd4, 16'd12));
        emit(alu_word(ooo_pkg::alu_addi, 4'd4, 4'd4, 4'd0, 16'h7777));
        emit(alu_word(ooo_pkg::alu_xor, 4'd6, 4'd4, 4'd4, 16'd0));
        emit(branch_word(ooo_pkg::br_bne, 4'd4, 4'd4, 16'd8));
        emit(branch_word(ooo_pkg::br_blt, 4'd3, 4'd3, 16'd8));
        // taken on a source still in flight
        emit(alu_word(ooo_pkg::alu_addi, 4'd7, 4'd0, 4'd0, 16'd1));
        emit(branch_word(ooo_pkg::br_blt, 4'd0, 4'd7, 16'd8));
        emit(alu_word(ooo_pkg::alu_add, 4'd7, 4'd7, 4'd7, 16'd0));
        // alu traffic starves the branch result while the rob fills
        for (int i = 0; i < 3; i++) begin
            emit(alu_word(ooo_pkg::alu_addi, 4'd8, 4'd8, 4'd0, 16'd3));
            emit(branch_word(ooo_pkg::br_bne, 4'd9, 4'd9, 16'd4));
            for (int j = 0; j < 10; j++) begin
                emit(alu_word(3'(j % 5), 4'(10 + j % 4), 4'(1 + j % 3), 4'd5, 16'd0));
            end
        end
        emit(branch_word(ooo_pkg::br_beq, 4'd9, 4'd9, 16'd4));
        // random tail with forward branches that never pass the end
        for (int i = 0; i < random_len; i++) begin
            if ($urandom % 5 == 0) begin
                k = 1 + int'($urandom % 6);
                if (i + k > random_len) begin
                    k = random_len - i;
                end
                emit(branch_word(3'($urandom % 3), 4'($urandom), 4'($urandom), 16'(4 * k)));
            end else begin
                emit(alu_word(3'($urandom % 7), 4'($urandom), 4'($urandom), 4'($urandom),
                              16'($urandom)));
            end
        end
    endtask

    task automatic report_counts();
        $display("commits %0d, flushes %0d, errors %0d", commit_count, flush_count, error_count);
    endtask

    task automatic check_commit();
        logic [31:0] word;
        logic [3:0]  exp_reg;
        logic [31:0] exp_data;
        logic [31:0] exp_npc;
        logic        exp_flush;
        if (ref_done) begin
            $display("commit seen after the last instruction of the program retired");
            error_count++;
        end else begin
            word = prog[ref_pc[10:2]];
            ref_execute(ref_regs, ref_pc, word, exp_reg, exp_data, exp_npc, exp_flush);
            assert (commit_reg == exp_reg) else begin
                $display("Mismatch commit_reg at pc %h: expected %h, got %h",
                         ref_pc, exp_reg, commit_reg);
                error_count++;
            end
            assert (commit_data == exp_data) else begin
                $display("Mismatch commit_data at pc %h: expected %h, got %h",
                         ref_pc, exp_data, commit_data);
                error_count++;
            end
            assert (commit_npc == exp_npc) else begin
                $display("Mismatch commit_npc at pc %h: expected %h, got %h",
                         ref_pc, exp_npc, commit_npc);
                error_count++;
            end
            assert (flush == exp_flush) else begin
                $display("Mismatch flush at pc %h: expected %h, got %h", ref_pc, exp_flush, flush);
                error_count++;
            end
            commit_count++;
            if (flush) begin
                flush_count++;
            end
            ref_pc   = exp_npc;
            ref_done = ref_pc >= 32'(prog_len * 4);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n && commit_valid) begin
            check_commit();
        end
    end

    // fetch side that restarts at commit_npc on a flush
    initial begin
        logic [31:0] next_pc;
        wait (stim_go);
        next_pc = 32'd0;
        forever begin
            @(negedge clk);
            pc = next_pc;
            if (pc < 32'(prog_len * 4)) begin
                instr       = prog[pc[10:2]];
                instr_valid = ($urandom % 8) != 0;
            end else begin
                instr_valid = 1'b0;
            end
            @(posedge clk);
            if (flush) begin
                next_pc = commit_npc;
            end else if (instr_valid && instr_ready) begin
                next_pc = pc + 32'd4;
            end
        end
    end

    initial begin
        int budget;
        wait (stim_go);
        budget = (prog_len + branch_count) * 40;
        repeat (budget) @(posedge clk);
        $display("timeout: commit for pc %h never arrived within %0d cycles", ref_pc, budget);
        report_counts();
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(65));
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = 32'd0;
        pc           = 32'd0;
        stim_go      = 1'b0;
        ref_done     = 1'b0;
        ref_pc       = 32'd0;
        prog_len     = 0;
        branch_count = 0;
        error_count  = 0;
        commit_count = 0;
        flush_count  = 0;
        for (int r = 0; r < 16; r++) begin
            ref_regs[r] = 32'd0;
        end
        build_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        assert (!commit_valid && !flush && instr_ready) else begin
            $display("outputs wrong after reset: commit_valid %h, flush %h, instr_ready %h",
                     commit_valid, flush, instr_ready);
            error_count++;
        end
        stim_go = 1'b1;
        wait (ref_done);
        // stray commits past the end show up here
        repeat (drain_cycles) @(posedge clk);
        report_counts();
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: ooo_core.f
+incdir+verification
hdl/ooo_pkg.sv
hdl/ooo_ifs.sv
hdl/arch_regfile.sv
hdl/dispatch_unit.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/cdb_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
verification/ooo_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build ooo_core_tb with Verilator, run it, and decide on the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ooo_core_tb \
    -f ooo_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vooo_core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
echo "pass message not found"
exit 1
